// File: logic/cache_geom_pkg.sv
package cache_geom_pkg;

    // physical address and cpu word
    localparam int ADDR_W = 32;
    localparam int WORD_W = 64;
    localparam int STRB_W = WORD_W / 8;   // one strobe per byte

    // 16-byte line holding two cpu words
    localparam int LINE_W   = 128;
    localparam int OFFSET_W = $clog2(LINE_W / 8);

    // address bit OFFSET_W-1 picks the upper or lower word of a line

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LINE_W-1:0] line_t;

    // bit enables for data array writes
    typedef logic [LINE_W-1:0] line_mask_t;

    // two ways, so one bit
    typedef logic way_sel_t;

endpackage

// File: logic/cache_bus_pkg.sv
package cache_bus_pkg;
    import cache_geom_pkg::*;

    // cpu side request, captured by the cache on acceptance
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        word_t             wdata;
        logic [STRB_W-1:0] strb;    // byte enables, stores only
        logic              write;
    } cpu_req_t;

    // memory side request, one full line per beat
    // held stable from valid until the response pulse
    typedef struct packed {
        logic [ADDR_W-1:0] addr;    // always line aligned
        line_t             wdata;   // victim line on write-back
        logic              write;   // 1 write-back, 0 refill
    } mem_req_t;

endpackage

// File: logic/dcache_tag_array.sv
`timescale 1ns/10ps

module dcache_tag_array
    import cache_geom_pkg::*;
#(
    parameter int NUM_SETS = 128
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [ADDR_W-1:0] index_addr,
    input  logic              tag_fill,
    input  logic              tag_mark_dirty,
    input  way_sel_t          fill_way,
    input  logic              fill_dirty,
    output logic              hit_way0,
    output logic              hit_way1,
    output way_sel_t          victim_way,
    output logic              victim_dirty,
    output logic [ADDR_W-1:0] victim_tag_addr
);

    localparam int INDEX_W = $clog2(NUM_SETS);
    localparam int TAG_W   = ADDR_W - OFFSET_W - INDEX_W;

    logic [TAG_W-1:0]    tag_q [2][NUM_SETS];
    logic [NUM_SETS-1:0] valid_q [2];
    logic [NUM_SETS-1:0] dirty_q [2];
    logic [NUM_SETS-1:0] ptr_q;       // per-set replacement pointer

    logic [INDEX_W-1:0] idx;
    logic [TAG_W-1:0]   addr_tag;
    logic               set_full;

    assign idx      = index_addr[OFFSET_W +: INDEX_W];
    assign addr_tag = index_addr[ADDR_W-1 -: TAG_W];
    assign set_full = valid_q[0][idx] & valid_q[1][idx];

    assign hit_way0 = valid_q[0][idx] && (tag_q[0][idx] == addr_tag);
    assign hit_way1 = valid_q[1][idx] && (tag_q[1][idx] == addr_tag);

    // an empty way wins, otherwise follow the pointer
    always_comb begin
        if (!valid_q[0][idx])
            victim_way = 1'b0;
        else if (!valid_q[1][idx])
            victim_way = 1'b1;
        else
            victim_way = ptr_q[idx];
    end

    assign victim_dirty    = valid_q[victim_way][idx] & dirty_q[victim_way][idx];
    assign victim_tag_addr = {tag_q[victim_way][idx], idx, {OFFSET_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            dirty_q[0] <= '0;
            dirty_q[1] <= '0;
            ptr_q      <= '0;
        end else begin
            if (tag_fill) begin
                valid_q[fill_way][idx] <= 1'b1;
                dirty_q[fill_way][idx] <= fill_dirty;  // write miss allocates dirty
                if (set_full)
                    ptr_q[idx] <= ~ptr_q[idx];         // replacement in a full set
            end
            if (tag_mark_dirty) begin
                if (hit_way0)
                    dirty_q[0][idx] <= 1'b1;
                else if (hit_way1)
                    dirty_q[1][idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tag_fill)
            tag_q[fill_way][idx] <= addr_tag;
    end

endmodule

// File: logic/dcache_data_array.sv
`timescale 1ns/10ps

module dcache_data_array
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;
#(
    parameter int NUM_SETS = 128
) (
    input  logic              clk,
    input  logic [ADDR_W-1:0] rd_index_addr,
    input  cpu_req_t          req_q,
    input  logic              data_write_hit,
    input  logic              data_fill,
    input  way_sel_t          wr_way,
    input  logic              hit_way0,
    input  line_t             mem_rsp_rdata,
    output word_t             rd_word,
    output line_t             victim_line
);

    localparam int INDEX_W = $clog2(NUM_SETS);

    line_t line_q [2][NUM_SETS];
    line_t rd_line_q [2];             // synchronous read port, both ways
    word_t fill_word_q;
    logic  fill_hold_q;

    logic [INDEX_W-1:0] rd_idx;
    logic [INDEX_W-1:0] wr_idx;
    logic               upper;
    word_t              word_mask;
    line_mask_t         store_mask;
    line_mask_t         wr_mask;
    line_t              store_line;
    line_t              merged_line;
    line_t              wr_line;
    way_sel_t           wr_sel;
    logic               wr_en;
    word_t              hit_word;

    function automatic word_t pick_word(line_t line, logic hi);
        return hi ? line[LINE_W-1 -: WORD_W] : line[WORD_W-1:0];
    endfunction

    assign rd_idx = rd_index_addr[OFFSET_W +: INDEX_W];
    assign wr_idx = req_q.addr[OFFSET_W +: INDEX_W];
    assign upper  = req_q.addr[OFFSET_W-1];

    // byte strobes to bit mask
    always_comb begin
        for (int b = 0; b < STRB_W; b++)
            word_mask[8*b +: 8] = {8{req_q.strb[b]}};
    end

    assign store_mask = upper ? {word_mask, {WORD_W{1'b0}}} : {{WORD_W{1'b0}}, word_mask};
    assign store_line = {req_q.wdata, req_q.wdata};

    // a pending store lands on top of the refilled line
    assign merged_line = req_q.write ?
                         (mem_rsp_rdata & ~store_mask) | (store_line & store_mask) :
                         mem_rsp_rdata;

    assign wr_en   = data_write_hit | data_fill;
    assign wr_sel  = data_fill ? wr_way : way_sel_t'(!hit_way0);
    assign wr_mask = data_fill ? '1 : store_mask;
    assign wr_line = data_fill ? merged_line : store_line;

    always_ff @(posedge clk) begin
        if (wr_en)
            line_q[wr_sel][wr_idx] <= (line_q[wr_sel][wr_idx] & ~wr_mask) | (wr_line & wr_mask);
        rd_line_q[0] <= line_q[0][rd_idx];
        rd_line_q[1] <= line_q[1][rd_idx];
    end

    // the filled word is kept for the response cycle
    always_ff @(posedge clk) begin
        fill_hold_q <= data_fill;
        if (data_fill)
            fill_word_q <= pick_word(merged_line, upper);
    end

    assign hit_word    = pick_word(hit_way0 ? rd_line_q[0] : rd_line_q[1], upper);
    assign rd_word     = fill_hold_q ? fill_word_q : hit_word;
    assign victim_line = rd_line_q[wr_way];

endmodule

// File: logic/dcache_ctrl.sv
`timescale 1ns/10ps

module dcache_ctrl
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    // cpu port
    input  cpu_req_t          cpu_req,
    input  logic              cpu_req_valid,
    output logic              cpu_req_ready,
    output logic              cpu_rsp_valid,
    output word_t             cpu_rsp_rdata,

    // memory port
    output mem_req_t          mem_req,
    output logic              mem_req_valid,
    input  logic              mem_rsp_valid,

    // to the arrays
    output cpu_req_t          req_q,
    output logic              tag_fill,
    output logic              tag_mark_dirty,
    output logic              data_write_hit,
    output logic              data_fill,
    output way_sel_t          fill_way,

    // from the arrays
    input  logic              hit_way0,
    input  logic              hit_way1,
    input  way_sel_t          victim_way,
    input  logic              victim_dirty,
    input  logic [ADDR_W-1:0] victim_tag_addr,
    input  word_t             rd_word,
    input  line_t             victim_line
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        RESPOND
    } state_e;

    state_e   state_q;
    state_e   state_d;
    way_sel_t victim_q;   // way chosen at lookup, filled later

    logic     accept;
    logic     hit;
    logic     miss;
    logic     refill_issue;
    mem_req_t wb_req;
    mem_req_t refill_req;

    assign accept = cpu_req_valid & cpu_req_ready;
    assign hit    = hit_way0 | hit_way1;
    assign miss   = (state_q == LOOKUP) & !hit;

    // refill goes out once the write-back handshake has closed
    assign refill_issue = (state_q == REFILL) & !mem_req_valid;

    always_comb begin
        wb_req.addr  = victim_tag_addr;
        wb_req.wdata = victim_line;
        wb_req.write = 1'b1;
    end

    always_comb begin
        refill_req.addr  = {req_q.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        refill_req.wdata = '0;
        refill_req.write = 1'b0;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept)
                    state_d = LOOKUP;
            end
            LOOKUP: begin
                if (hit)
                    state_d = IDLE;
                else if (victim_dirty)
                    state_d = WRITEBACK;
                else
                    state_d = REFILL;
            end
            WRITEBACK: begin
                if (mem_rsp_valid)
                    state_d = REFILL;
            end
            REFILL: begin
                if (mem_rsp_valid)
                    state_d = RESPOND;
            end
            RESPOND: state_d = IDLE;   // filled word goes out here
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q       <= IDLE;
            mem_req_valid <= 1'b0;
        end else begin
            state_q <= state_d;
            if (miss || refill_issue)
                mem_req_valid <= 1'b1;
            else if (mem_rsp_valid)
                mem_req_valid <= 1'b0;   // drops the cycle after the response
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            req_q <= cpu_req;
        if (miss) begin
            victim_q <= victim_way;
            mem_req  <= victim_dirty ? wb_req : refill_req;
        end else if (refill_issue) begin
            mem_req <= refill_req;
        end
    end

    // live victim during lookup so the array can present its line
    assign fill_way = (state_q == LOOKUP) ? victim_way : victim_q;

    assign data_fill      = (state_q == REFILL) & mem_rsp_valid;
    assign tag_fill       = data_fill;
    assign data_write_hit = (state_q == LOOKUP) & hit & req_q.write;
    assign tag_mark_dirty = data_write_hit;

    assign cpu_req_ready = (state_q == IDLE);
    assign cpu_rsp_valid = ((state_q == LOOKUP) & hit) | (state_q == RESPOND);
    assign cpu_rsp_rdata = rd_word;

endmodule

// File: logic/dcache_top.sv
`timescale 1ns/10ps

module dcache_top
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;
#(
    parameter int NUM_SETS = 128
) (
    input  logic     clk,
    input  logic     rst,
    input  cpu_req_t cpu_req,
    input  logic     cpu_req_valid,
    output logic     cpu_req_ready,
    output logic     cpu_rsp_valid,
    output word_t    cpu_rsp_rdata,
    output mem_req_t mem_req,
    output logic     mem_req_valid,
    input  logic     mem_rsp_valid,
    input  line_t    mem_rsp_rdata
);

    cpu_req_t          req_q;
    logic              tag_fill;
    logic              tag_mark_dirty;
    logic              data_write_hit;
    logic              data_fill;
    way_sel_t          fill_way;
    logic              hit_way0;
    logic              hit_way1;
    way_sel_t          victim_way;
    logic              victim_dirty;
    logic [ADDR_W-1:0] victim_tag_addr;
    word_t             rd_word;
    line_t             victim_line;

    dcache_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .cpu_req         (cpu_req),
        .cpu_req_valid   (cpu_req_valid),
        .cpu_req_ready   (cpu_req_ready),
        .cpu_rsp_valid   (cpu_rsp_valid),
        .cpu_rsp_rdata   (cpu_rsp_rdata),
        .mem_req         (mem_req),
        .mem_req_valid   (mem_req_valid),
        .mem_rsp_valid   (mem_rsp_valid),
        .req_q           (req_q),
        .tag_fill        (tag_fill),
        .tag_mark_dirty  (tag_mark_dirty),
        .data_write_hit  (data_write_hit),
        .data_fill       (data_fill),
        .fill_way        (fill_way),
        .hit_way0        (hit_way0),
        .hit_way1        (hit_way1),
        .victim_way      (victim_way),
        .victim_dirty    (victim_dirty),
        .victim_tag_addr (victim_tag_addr),
        .rd_word         (rd_word),
        .victim_line     (victim_line)
    );

    // tags follow the latched request
    dcache_tag_array #(
        .NUM_SETS (NUM_SETS)
    ) u_tags (
        .clk             (clk),
        .rst             (rst),
        .index_addr      (req_q.addr),
        .tag_fill        (tag_fill),
        .tag_mark_dirty  (tag_mark_dirty),
        .fill_way        (fill_way),
        .fill_dirty      (req_q.write),
        .hit_way0        (hit_way0),
        .hit_way1        (hit_way1),
        .victim_way      (victim_way),
        .victim_dirty    (victim_dirty),
        .victim_tag_addr (victim_tag_addr)
    );

    // data read starts from the incoming address at acceptance
    dcache_data_array #(
        .NUM_SETS (NUM_SETS)
    ) u_data (
        .clk            (clk),
        .rd_index_addr  (cpu_req.addr),
        .req_q          (req_q),
        .data_write_hit (data_write_hit),
        .data_fill      (data_fill),
        .wr_way         (fill_way),
        .hit_way0       (hit_way0),
        .mem_rsp_rdata  (mem_rsp_rdata),
        .rd_word        (rd_word),
        .victim_line    (victim_line)
    );

endmodule

// File: sim/dcache_mem_model.sv
`timescale 1ns/10ps

module dcache_mem_model
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;
#(
    parameter logic [31:0] SEED = 32'h03af_48f4
) (
    input  logic     clk,
    input  logic     rst,
    input  mem_req_t mem_req,
    input  logic     mem_req_valid,
    output logic     mem_rsp_valid,
    output line_t    mem_rsp_rdata
);

    line_t             lines [logic [ADDR_W-1:0]];   // only lines written back
    int                refill_count;
    int                wb_count;
    logic [ADDR_W-1:0] last_refill_addr;
    logic [ADDR_W-1:0] wb_addr_q [$];
    line_t             wb_data_q [$];

    // untouched memory holds addr[7:0] ^ 5a in every byte
    function automatic line_t pattern_line(logic [ADDR_W-1:0] addr);
        line_t l;
        for (int b = 0; b < LINE_W / 8; b++)
            l[8*b +: 8] = 8'(addr + b) ^ 8'h5a;
        return l;
    endfunction

    initial begin
        int unsigned delay;
        void'($urandom(SEED));
        mem_rsp_valid = 1'b0;
        mem_rsp_rdata = '0;
        refill_count  = 0;
        wb_count      = 0;
        forever begin
            @(negedge clk);
            if (mem_req_valid && !rst) begin
                delay = $urandom_range(1, 4);
                repeat (delay) @(negedge clk);
                if (mem_req.write) begin
                    lines[mem_req.addr] = mem_req.wdata;
                    wb_addr_q.push_back(mem_req.addr);
                    wb_data_q.push_back(mem_req.wdata);
                    wb_count++;
                    mem_rsp_rdata = '0;
                end else begin
                    last_refill_addr = mem_req.addr;
                    refill_count++;
                    mem_rsp_rdata = lines.exists(mem_req.addr) ? lines[mem_req.addr] :
                                    pattern_line(mem_req.addr);
                end
                mem_rsp_valid = 1'b1;
                @(negedge clk);
                mem_rsp_valid = 1'b0;   // single cycle pulse
            end
        end
    end

endmodule

// File: sim/dcache_assert.sv
`timescale 1ns/10ps

module dcache_assert
    import cache_bus_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     cpu_req_ready,
    input logic     cpu_rsp_valid,
    input mem_req_t mem_req,
    input logic     mem_req_valid,
    input logic     mem_rsp_valid
);

    // request held until the memory answers
    mem_req_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_rsp_valid |=> $stable(mem_req))
        else $error("mem_req changed while waiting for the response");

    rsp_single_pulse: assert property (@(posedge clk) disable iff (rst)
        cpu_rsp_valid |=> !cpu_rsp_valid)
        else $error("cpu_rsp_valid high two cycles in a row");

    ready_while_busy: assert property (@(posedge clk) disable iff (rst)
        !(cpu_req_ready && mem_req_valid))
        else $error("cpu_req_ready high during a memory request");

endmodule

bind dcache_top dcache_assert u_assert (.*);

// File: sim/dcache_tb.sv
`timescale 1ns/10ps

module dcache_tb
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;
;

    localparam int NUM_ROWS     = 24;
    localparam int RESET_CYCLES = 4;
    localparam int PERIOD       = 20;

    typedef struct packed {
        logic              rst_before;   // second reset ahead of this row
        logic              write;
        logic [ADDR_W-1:0] addr;
        word_t             wdata;
        logic [STRB_W-1:0] strb;
        word_t             rdata;
        logic              hit;
        logic              wb;
    } row_t;

    logic     clk;
    logic     rst;
    cpu_req_t cpu_req;
    logic     cpu_req_valid;
    logic     cpu_req_ready;
    logic     cpu_rsp_valid;
    word_t    cpu_rsp_rdata;
    mem_req_t mem_req;
    logic     mem_req_valid;
    logic     mem_rsp_valid;
    line_t    mem_rsp_rdata;

    row_t  rows [NUM_ROWS];
    line_t shadow [logic [ADDR_W-1:0]];   // cpu visible memory
    int    errors;

    dcache_top #(.NUM_SETS(128)) dut0 (.*);

    dcache_mem_model #(.SEED(32'h03af_48f4)) mem0 (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((NUM_ROWS * 40 + 2 * RESET_CYCLES) * PERIOD);
        $display("watchdog expired, the cache stopped answering");
        $display("TESTBENCH FAILED");
        $finish;
    end

    task automatic check_value(string name, logic [127:0] got, logic [127:0] exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic line_t initial_line(logic [ADDR_W-1:0] addr);
        line_t l;
        for (int b = 0; b < 16; b++)
            l[8*b +: 8] = 8'(addr + b) ^ 8'h5a;
        return l;
    endfunction

    function automatic line_t shadow_line(logic [ADDR_W-1:0] addr);
        return shadow.exists(addr) ? shadow[addr] : initial_line(addr);
    endfunction

    task automatic apply_reset();
        rst = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic run_row(int n, row_t r);
        int                refills;
        int                wbs;
        int                lat;
        logic [ADDR_W-1:0] base;
        line_t             l;
        refills = mem0.refill_count;
        wbs     = mem0.wb_count;
        base    = {r.addr[ADDR_W-1:4], 4'h0};
        cpu_req       = '{addr: r.addr, wdata: r.wdata, strb: r.strb, write: r.write};
        cpu_req_valid = 1'b1;
        while (!cpu_req_ready)
            @(negedge clk);
        @(negedge clk);
        cpu_req_valid = 1'b0;
        lat = 1;
        while (!cpu_rsp_valid) begin
            if (cpu_req_ready) begin
                $display("row %0d: cpu_req_ready went high while a miss was pending", n);
                errors++;
            end
            @(negedge clk);
            lat++;
        end
        if (!r.write)
            check_value("cpu_rsp_rdata", cpu_rsp_rdata, r.rdata);
        check_value("refill count", mem0.refill_count - refills, r.hit ? 0 : 1);
        check_value("write-back count", mem0.wb_count - wbs, r.wb);
        if (r.hit)
            check_value("hit latency", lat, 1);
        else begin
            check_value("refill addr", mem0.last_refill_addr, base);
            if (lat < 4) begin
                $display("row %0d: miss answered after only %0d cycles", n, lat);
                errors++;
            end
        end
        while (mem0.wb_addr_q.size() > 0)   // victim must carry what the cpu wrote
            check_value("write-back data", mem0.wb_data_q.pop_front(),
                        shadow_line(mem0.wb_addr_q.pop_front()));
        if (r.write) begin
            l = shadow_line(base);
            for (int b = 0; b < STRB_W; b++)
                if (r.strb[b])
                    l[64*r.addr[3] + 8*b +: 8] = r.wdata[8*b +: 8];
            shadow[base] = l;
        end
    endtask

    initial begin
        // rst, write, addr, wdata, strb, rdata, hit, wb
        rows[0]  = '{0, 0, 32'h0100, 64'h0, 8'h00, 64'h5d5c5f5e_59585b5a, 0, 0};
        rows[1]  = '{0, 0, 32'h0108, 64'h0, 8'h00, 64'h55545756_51505352, 1, 0};
        rows[2]  = '{0, 1, 32'h0100, 64'h11223344_55667788, 8'h0f, 64'h0, 1, 0};
        rows[3]  = '{0, 0, 32'h0100, 64'h0, 8'h00, 64'h5d5c5f5e_55667788, 1, 0};
        rows[4]  = '{0, 1, 32'h0218, 64'haabbccdd_eeff0011, 8'hf0, 64'h0, 0, 0};
        rows[5]  = '{0, 0, 32'h0218, 64'h0, 8'h00, 64'haabbccdd_41404342, 1, 0};
        rows[6]  = '{0, 0, 32'h0210, 64'h0, 8'h00, 64'h4d4c4f4e_49484b4a, 1, 0};
        rows[7]  = '{0, 0, 32'h0900, 64'h0, 8'h00, 64'h5d5c5f5e_59585b5a, 0, 0};
        rows[8]  = '{0, 0, 32'h1100, 64'h0, 8'h00, 64'h5d5c5f5e_59585b5a, 0, 1};
        rows[9]  = '{0, 0, 32'h0108, 64'h0, 8'h00, 64'h55545756_51505352, 0, 0};
        rows[10] = '{0, 0, 32'h0100, 64'h0, 8'h00, 64'h5d5c5f5e_55667788, 1, 0};
        rows[11] = '{0, 1, 32'h1100, 64'hdeadbeef_cafef00d, 8'h3c, 64'h0, 1, 0};
        rows[12] = '{0, 0, 32'h1100, 64'h0, 8'h00, 64'h5d5cbeef_cafe5b5a, 1, 0};
        rows[13] = '{0, 1, 32'h1908, 64'h01020304_05060708, 8'h01, 64'h0, 0, 1};
        rows[14] = '{0, 0, 32'h1908, 64'h0, 8'h00, 64'h55545756_51505308, 1, 0};
        rows[15] = '{0, 0, 32'h1100, 64'h0, 8'h00, 64'h5d5cbeef_cafe5b5a, 0, 0};
        rows[16] = '{0, 0, 32'h0900, 64'h0, 8'h00, 64'h5d5c5f5e_59585b5a, 0, 1};
        rows[17] = '{0, 0, 32'h1908, 64'h0, 8'h00, 64'h55545756_51505308, 0, 0};
        rows[18] = '{0, 0, 32'h0218, 64'h0, 8'h00, 64'haabbccdd_41404342, 1, 0};
        rows[19] = '{1, 0, 32'h0218, 64'h0, 8'h00, 64'h45444746_41404342, 0, 0};
        rows[20] = '{0, 0, 32'h0210, 64'h0, 8'h00, 64'h4d4c4f4e_49484b4a, 1, 0};
        rows[21] = '{0, 1, 32'h0a10, 64'hffffffff_ffffffff, 8'h80, 64'h0, 0, 0};
        rows[22] = '{0, 0, 32'h1218, 64'h0, 8'h00, 64'h45444746_41404342, 0, 0};
        rows[23] = '{0, 0, 32'h2210, 64'h0, 8'h00, 64'h4d4c4f4e_49484b4a, 0, 1};

        errors        = 0;
        rst           = 1'b1;
        cpu_req       = '0;
        cpu_req_valid = 1'b0;
        apply_reset();
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].rst_before) begin
                apply_reset();
                shadow = mem0.lines;   // dirty lines are lost on reset
            end
            run_row(i, rows[i]);
        end
        repeat (2) @(negedge clk);
        $display("rows run: %0d, errors: %0d", NUM_ROWS, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: sim.f
logic/cache_geom_pkg.sv
logic/cache_bus_pkg.sv
logic/dcache_tag_array.sv
logic/dcache_data_array.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
sim/dcache_mem_model.sv
sim/dcache_assert.sv
sim/dcache_tb.sv
